// ==== logic/netdbg_pkg.sv ====
package netdbg_pkg;

	//////////////////////////////////////////////////////////////
	// Line side
	//////////////////////////////////////////////////////////////

	// One 66-bit block, sync header in the low two bits
	typedef logic [65:0] block_t;
	typedef logic [1:0] sync_t;

	localparam sync_t SYNC_CONTROL = 2'b01;
	localparam sync_t SYNC_DATA = 2'b10;

	// Eight zero idle characters, block type 1E, control header
	localparam block_t P_IDLE = {{8{7'h00}}, 8'h1e, SYNC_CONTROL};

	// 3 = PHY fault, 2 = remote, 1 = local, 0 = locked
	typedef logic [1:0] lock_t;

	typedef logic [17:0] pktlen_t;
	typedef logic [7:0] wordcnt_t;

	//////////////////////////////////////////////////////////////
	// Debug word
	//////////////////////////////////////////////////////////////

	typedef logic [30:0] dbg_word_t;
	typedef logic [2:0] chan_code_t;

	localparam chan_code_t CODE_IDLE = 3'd0;
	localparam chan_code_t CODE_RX = 3'd4;
	localparam chan_code_t CODE_CRC = 3'd5;
	localparam chan_code_t CODE_TX = 3'd6;
	localparam chan_code_t CODE_TXGATE = 3'd7;

	localparam int NUM_SOURCES = 5;
	typedef logic [$clog2(NUM_SOURCES)-1:0] src_idx_t;

	localparam int IDLE_COUNT_BITS = 12;
	localparam int FAULT_SYNC_STAGES = 3;

endpackage

// ==== logic/line_status.sv ====
`timescale 1ns/1ps

module line_status (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_phy_fault,
	input  logic                i_remote_fault,
	input  logic                i_local_fault,
	input  logic                i_p66b_valid,
	input  netdbg_pkg::block_t  i_p66b_data,
	output netdbg_pkg::lock_t   o_lock,
	output logic                o_phy_fault,
	output netdbg_pkg::wordcnt_t o_word_count,
	output logic                o_word_wrap,
	output netdbg_pkg::sync_t   o_last_sync
);
	import netdbg_pkg::*;

	logic [FAULT_SYNC_STAGES-1:0] fault_pipe;
	lock_t last_lock;

	// PHY fault crosses in from another domain, so it reads as faulted until flushed
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			fault_pipe <= '1;
		else
			fault_pipe <= {fault_pipe[FAULT_SYNC_STAGES-2:0], i_phy_fault};
	end

	assign o_phy_fault = fault_pipe[FAULT_SYNC_STAGES-1];

	// Priority encode, PHY fault first
	always_comb
	begin
		if (o_phy_fault)
			o_lock = 2'd3;
		else if (i_remote_fault)
			o_lock = 2'd2;
		else if (i_local_fault)
			o_lock = 2'd1;
		else
			o_lock = 2'd0;
	end

	//////////////////////////////////////////////////////////////
	// Coarse timestamp
	//////////////////////////////////////////////////////////////

	// Carry out pulses once per 256 valid blocks
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			{o_word_wrap, o_word_count} <= '0;
		else if (i_p66b_valid)
			{o_word_wrap, o_word_count} <= {1'b0, o_word_count} + 9'd1;
		else
			o_word_wrap <= 1'b0;
	end

	// Header 11 marks a lock change seen between blocks
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			last_lock <= 2'd3;
			o_last_sync <= 2'b11;
		end
		else
		begin
			last_lock <= o_lock;
			if (i_p66b_valid)
				o_last_sync <= i_p66b_data[1:0];
			else if (o_lock != last_lock)
				o_last_sync <= 2'b11;
		end
	end

endmodule

// ==== logic/idle_monitor.sv ====
`timescale 1ns/1ps

module idle_monitor (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_p66b_valid,
	input  netdbg_pkg::block_t   i_p66b_data,
	input  netdbg_pkg::lock_t    i_lock,
	input  logic                 i_phy_fault,
	input  logic                 i_word_wrap,
	output logic                 o_valid,
	input  logic                 i_ready,
	output netdbg_pkg::dbg_word_t o_data
);
	import netdbg_pkg::*;

	// Top bit set means saturated
	logic [IDLE_COUNT_BITS:0] idle_count;
	logic saturated;
	logic break_block;

	assign saturated = idle_count[IDLE_COUNT_BITS];

	// Only a non-idle block on a locked link restarts the count
	assign break_block = i_p66b_valid && (i_lock == 2'd0) && (i_p66b_data != P_IDLE);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			idle_count <= '0;
		else if (break_block)
			idle_count <= '0;
		else if (i_p66b_valid && !saturated)
			idle_count <= idle_count + 1'b1;
	end

	// Report once per timestamp wrap, held until taken
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else if (i_word_wrap && saturated && !i_phy_fault)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;
	end

	// Fixed report word, value 1
	assign o_data = {2'b00, CODE_IDLE, 24'h0, SYNC_CONTROL};

endmodule

// ==== logic/pkt_stat_channel.sv ====
`timescale 1ns/1ps

module pkt_stat_channel #(
	parameter netdbg_pkg::chan_code_t CODE = netdbg_pkg::CODE_RX
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_packet,
	input  netdbg_pkg::pktlen_t   i_pktlen,
	input  netdbg_pkg::lock_t     i_lock,
	input  netdbg_pkg::wordcnt_t  i_word_count,
	input  logic                  i_p66b_valid,
	input  netdbg_pkg::sync_t     i_sync,
	input  netdbg_pkg::sync_t     i_last_sync,
	output logic                  o_valid,
	input  logic                  i_ready,
	output netdbg_pkg::dbg_word_t o_data
);
	import netdbg_pkg::*;

	sync_t cur_sync;
	logic can_load;

	// No block this cycle, so fall back on the tracked header
	assign cur_sync = i_p66b_valid ? i_sync : i_last_sync;
	assign can_load = !o_valid || i_ready;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else if (i_packet)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;
	end

	// A strobe while a word waits ungranted is lost
	always_ff @(posedge i_clk)
	begin
		if (can_load && i_packet)
			o_data <= {i_lock, CODE, i_word_count[7:2], i_pktlen, cur_sync};
	end

endmodule

// ==== logic/dbg_arbiter.sv ====
`timescale 1ns/1ps

module dbg_arbiter (
	input  logic                            i_clk,
	input  logic                            i_reset,
	input  logic [netdbg_pkg::NUM_SOURCES-1:0] i_valid,
	output logic [netdbg_pkg::NUM_SOURCES-1:0] o_ready,
	input  netdbg_pkg::dbg_word_t           i_data [netdbg_pkg::NUM_SOURCES],
	output logic                            o_dbg_valid,
	input  logic                            i_dbg_ready,
	output netdbg_pkg::dbg_word_t           o_dbg_data
);
	import netdbg_pkg::*;

	src_idx_t last_grant;
	src_idx_t grant_idx;
	logic grant_found;
	logic load;

	// Output register is free this cycle
	assign load = !o_dbg_valid || i_dbg_ready;

	//////////////////////////////////////////////////////////////
	// Round-robin search
	//////////////////////////////////////////////////////////////

	// Start one past the last winner and wrap
	always_comb
	begin
		int idx;
		grant_found = 1'b0;
		grant_idx = last_grant;
		for (int k = 1; k <= NUM_SOURCES; k++)
		begin
			idx = (int'(last_grant) + k) % NUM_SOURCES;
			if (!grant_found && i_valid[idx])
			begin
				grant_found = 1'b1;
				grant_idx = src_idx_t'(idx);
			end
		end
	end

	// At most one ready, and none under back-pressure
	always_comb
	begin
		o_ready = '0;
		if (load && grant_found)
			o_ready[grant_idx] = 1'b1;
	end

	//////////////////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_dbg_valid <= 1'b0;
			o_dbg_data <= '0;
			last_grant <= src_idx_t'(NUM_SOURCES - 1);
		end
		else if (load)
		begin
			o_dbg_valid <= grant_found;
			if (grant_found)
			begin
				o_dbg_data <= i_data[grant_idx];
				last_grant <= grant_idx;
			end
		end
	end

endmodule

// ==== logic/netdbggen.sv ====
`timescale 1ns/1ps

module netdbggen (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_phy_fault,
	input  logic                  i_remote_fault,
	input  logic                  i_local_fault,
	// Raw block stream, never stalled
	input  logic                  i_p66b_valid,
	input  netdbg_pkg::block_t    i_p66b_data,
	// Packet completion strobes
	input  logic                  i_rx_packet,
	input  netdbg_pkg::pktlen_t   i_rx_pktlen,
	input  logic                  i_crc_packet,
	input  netdbg_pkg::pktlen_t   i_crc_pktlen,
	input  logic                  i_txgate_packet,
	input  netdbg_pkg::pktlen_t   i_txgate_pktlen,
	input  logic                  i_tx_packet,
	input  netdbg_pkg::pktlen_t   i_tx_pktlen,
	// Debug word stream
	output logic                  o_dbg_valid,
	input  logic                  i_dbg_ready,
	output netdbg_pkg::dbg_word_t o_dbg_data
);
	import netdbg_pkg::*;

	lock_t lock;
	logic phy_fault;
	wordcnt_t word_count;
	logic word_wrap;
	sync_t last_sync;

	// 0 idle, 1 rx, 2 crc, 3 txgate, 4 tx
	logic [NUM_SOURCES-1:0] src_valid;
	logic [NUM_SOURCES-1:0] src_ready;
	dbg_word_t src_data [NUM_SOURCES];

	line_status u_status (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_phy_fault(i_phy_fault), .i_remote_fault(i_remote_fault),
		.i_local_fault(i_local_fault),
		.i_p66b_valid(i_p66b_valid), .i_p66b_data(i_p66b_data),
		.o_lock(lock), .o_phy_fault(phy_fault),
		.o_word_count(word_count), .o_word_wrap(word_wrap),
		.o_last_sync(last_sync)
	);

	idle_monitor u_idle (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_p66b_valid(i_p66b_valid), .i_p66b_data(i_p66b_data),
		.i_lock(lock), .i_phy_fault(phy_fault), .i_word_wrap(word_wrap),
		.o_valid(src_valid[0]), .i_ready(src_ready[0]), .o_data(src_data[0])
	);

	//////////////////////////////////////////////////////////////
	// Packet statistics
	//////////////////////////////////////////////////////////////

	pkt_stat_channel #(.CODE(CODE_RX)) u_rx (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_packet(i_rx_packet), .i_pktlen(i_rx_pktlen),
		.i_lock(lock), .i_word_count(word_count),
		.i_p66b_valid(i_p66b_valid), .i_sync(i_p66b_data[1:0]),
		.i_last_sync(last_sync),
		.o_valid(src_valid[1]), .i_ready(src_ready[1]), .o_data(src_data[1])
	);

	pkt_stat_channel #(.CODE(CODE_CRC)) u_crc (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_packet(i_crc_packet), .i_pktlen(i_crc_pktlen),
		.i_lock(lock), .i_word_count(word_count),
		.i_p66b_valid(i_p66b_valid), .i_sync(i_p66b_data[1:0]),
		.i_last_sync(last_sync),
		.o_valid(src_valid[2]), .i_ready(src_ready[2]), .o_data(src_data[2])
	);

	pkt_stat_channel #(.CODE(CODE_TXGATE)) u_txgate (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_packet(i_txgate_packet), .i_pktlen(i_txgate_pktlen),
		.i_lock(lock), .i_word_count(word_count),
		.i_p66b_valid(i_p66b_valid), .i_sync(i_p66b_data[1:0]),
		.i_last_sync(last_sync),
		.o_valid(src_valid[3]), .i_ready(src_ready[3]), .o_data(src_data[3])
	);

	pkt_stat_channel #(.CODE(CODE_TX)) u_tx (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_packet(i_tx_packet), .i_pktlen(i_tx_pktlen),
		.i_lock(lock), .i_word_count(word_count),
		.i_p66b_valid(i_p66b_valid), .i_sync(i_p66b_data[1:0]),
		.i_last_sync(last_sync),
		.o_valid(src_valid[4]), .i_ready(src_ready[4]), .o_data(src_data[4])
	);

	dbg_arbiter u_arb (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_valid(src_valid), .o_ready(src_ready), .i_data(src_data),
		.o_dbg_valid(o_dbg_valid), .i_dbg_ready(i_dbg_ready),
		.o_dbg_data(o_dbg_data)
	);

endmodule

// ==== tb/netdbggen_props.sv ====
`timescale 1ns/1ps

module netdbggen_props (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_dbg_valid,
	input  logic                  i_dbg_ready,
	input  netdbg_pkg::dbg_word_t i_dbg_data
);
	import netdbg_pkg::*;

	// Output register comes out of reset empty
	a_reset_empty: assert property (@(posedge i_clk) i_reset |=> !i_dbg_valid)
		else $error("o_dbg_valid high right after reset");

	// A stalled word stays put
	a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		i_dbg_valid && !i_dbg_ready |=> i_dbg_valid && $stable(i_dbg_data))
		else $error("output stream changed while i_dbg_ready was low");

	a_code: assert property (@(posedge i_clk) disable iff (i_reset)
		i_dbg_data[28:26] == CODE_IDLE || i_dbg_data[28:26] == CODE_RX
		|| i_dbg_data[28:26] == CODE_CRC || i_dbg_data[28:26] == CODE_TX
		|| i_dbg_data[28:26] == CODE_TXGATE)
		else $error("o_dbg_data holds an undefined source code");

endmodule

bind netdbggen netdbggen_props u_props (
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_dbg_valid(o_dbg_valid),
	.i_dbg_ready(i_dbg_ready),
	.i_dbg_data(o_dbg_data)
);

// ==== tb/netdbggen_tb.sv ====
`timescale 1ns/1ps

module netdbggen_tb;
	import netdbg_pkg::*;

	// Idle saturation dominates, the other tests need well under 2000 cycles
	localparam int TIMEOUT_CYCLES = (1 << IDLE_COUNT_BITS) + 2000;
	localparam chan_code_t CHAN_CODES [4] = '{CODE_RX, CODE_CRC, CODE_TXGATE, CODE_TX};

	logic i_clk;
	logic i_reset;
	logic i_phy_fault;
	logic i_remote_fault;
	logic i_local_fault;
	logic i_p66b_valid;
	block_t i_p66b_data;
	logic [3:0] strobe;
	pktlen_t pktlen [4];
	logic o_dbg_valid;
	logic i_dbg_ready;
	dbg_word_t o_dbg_data;

	logic [31:0] lfsr_state;
	int errors;
	int start_errors;
	int tests_failed;
	int tests_run;
	int cycle_count;
	int idle_count;
	int idle_seen;
	wordcnt_t model_count;
	sync_t model_last_sync;
	dbg_word_t exp_q [$];
	logic hold_prev;
	dbg_word_t prev_data;
	// Values for the next driven cycle
	logic remote_en;
	logic local_en;
	logic phy_en;
	logic ready_en;
	pktlen_t len_next [4];

	netdbggen DUT (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_phy_fault(i_phy_fault), .i_remote_fault(i_remote_fault),
		.i_local_fault(i_local_fault),
		.i_p66b_valid(i_p66b_valid), .i_p66b_data(i_p66b_data),
		.i_rx_packet(strobe[0]), .i_rx_pktlen(pktlen[0]),
		.i_crc_packet(strobe[1]), .i_crc_pktlen(pktlen[1]),
		.i_txgate_packet(strobe[2]), .i_txgate_pktlen(pktlen[2]),
		.i_tx_packet(strobe[3]), .i_tx_pktlen(pktlen[3]),
		.o_dbg_valid(o_dbg_valid), .i_dbg_ready(i_dbg_ready), .o_dbg_data(o_dbg_data)
	);

	initial
	begin
		i_clk = 1'b0;
		forever
			#5 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[62:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return r;
	endfunction

	function automatic block_t data_block();
		return {rand_bits(64), rand_bits(1) != 0 ? SYNC_CONTROL : SYNC_DATA};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// One clock of stimulus, plus the expected words and the line model
	task automatic drive_cycle(input logic blk_valid, input block_t blk,
			input logic [3:0] mask, input lock_t lock);
		sync_t sync;
		sync = blk_valid ? blk[1:0] : model_last_sync;
		@(posedge i_clk);
		i_p66b_valid <= blk_valid;
		i_p66b_data <= blk;
		strobe <= mask;
		i_remote_fault <= remote_en;
		i_local_fault <= local_en;
		i_phy_fault <= phy_en;
		i_dbg_ready <= ready_en;
		for (int c = 0; c < 4; c++)
		begin
			pktlen[c] <= len_next[c];
			if (mask[c])
				exp_q.push_back({lock, CHAN_CODES[c], model_count[7:2], len_next[c], sync});
		end
		if (blk_valid)
		begin
			model_last_sync = blk[1:0];
			model_count++;
			if (blk != P_IDLE && lock == 2'd0)
				idle_count = 0;
			else if (idle_count < (1 << IDLE_COUNT_BITS))
				idle_count++;
			// Timestamp wrap with a saturated idle count
			if (model_count == 0 && idle_count == (1 << IDLE_COUNT_BITS))
				exp_q.push_back(31'd1);
		end
	endtask

	task automatic wait_for_words(input int max_cycles);
		int n;
		n = 0;
		ready_en = 1'b1;
		while (exp_q.size() > 0 && n < max_cycles)
		begin
			drive_cycle(1'b0, '0, 4'b0, 2'd0);
			n++;
		end
		if (exp_q.size() > 0)
		begin
			$display("%0d expected debug words never came out by %0t ns", exp_q.size(), $time);
			errors++;
			exp_q.delete();
		end
		// A surplus word would show up here
		repeat (8)
			drive_cycle(1'b0, '0, 4'b0, 2'd0);
	endtask

	// Words of one source come in order, sources interleave freely
	task automatic match_word(input dbg_word_t got);
		int idx;
		idx = -1;
		if (got[28:26] == CODE_IDLE)
			idle_seen++;
		foreach (exp_q[i])
			if (idx < 0 && exp_q[i][28:26] == got[28:26])
				idx = i;
		if (idx < 0)
		begin
			$display("Unexpected debug word %h at %0t ns", got, $time);
			errors++;
		end
		else
		begin
			check("o_dbg_data", got, exp_q[idx]);
			exp_q.delete(idx);
		end
	endtask

	// Output side sampled half a cycle away from the edges
	always @(negedge i_clk)
	begin
		if (hold_prev)
		begin
			check("o_dbg_valid", o_dbg_valid, 1);
			check("o_dbg_data", o_dbg_data, prev_data);
		end
		if (o_dbg_valid && i_dbg_ready)
			match_word(o_dbg_data);
		hold_prev = o_dbg_valid && !i_dbg_ready && !i_reset;
		prev_data = o_dbg_data;
	end

	task automatic report_test(input string name);
		tests_run++;
		if (errors == start_errors)
			$display("%s: ok", name);
		else
		begin
			$display("%s: %0d errors", name, errors - start_errors);
			tests_failed++;
		end
		start_errors = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic single_rx_word();
		repeat (9)
			drive_cycle(1'b1, data_block(), 4'b0, 2'd0);
		len_next[0] = pktlen_t'(rand_bits(18));
		drive_cycle(1'b1, data_block(), 4'b0001, 2'd0);
		wait_for_words(20);
	endtask

	task automatic all_four_strobes();
		for (int c = 0; c < 4; c++)
			len_next[c] = pktlen_t'(rand_bits(18));
		drive_cycle(1'b1, data_block(), 4'b1111, 2'd0);
		wait_for_words(40);
	endtask

	// Strobe only channels with nothing outstanding, so no strobe is dropped
	task automatic random_backpressure();
		logic [3:0] busy;
		for (int n = 0; n < 200; n++)
		begin
			busy = '0;
			foreach (exp_q[i])
				for (int c = 0; c < 4; c++)
					if (exp_q[i][28:26] == CHAN_CODES[c])
						busy[c] = 1'b1;
			for (int c = 0; c < 4; c++)
				len_next[c] = pktlen_t'(rand_bits(18));
			if (rand_bits(2) == 0)
				ready_en = !ready_en;
			drive_cycle(rand_bits(1) != 0, data_block(), 4'(rand_bits(4)) & ~busy, 2'd0);
		end
		wait_for_words(100);
	endtask

	// Idle blocks only, so the idle model stays independent of lock
	task automatic fault_priority();
		for (int c = 0; c < 4; c++)
			len_next[c] = pktlen_t'(rand_bits(18));
		local_en = 1'b1;
		drive_cycle(1'b1, P_IDLE, 4'b0001, 2'd1);
		remote_en = 1'b1;
		drive_cycle(1'b1, P_IDLE, 4'b0010, 2'd2);
		phy_en = 1'b1;
		drive_cycle(1'b0, '0, 4'b0000, 2'd2);
		drive_cycle(1'b0, '0, 4'b0000, 2'd2);
		// Synchronizer still shows the old value
		drive_cycle(1'b1, P_IDLE, 4'b0100, 2'd2);
		drive_cycle(1'b1, P_IDLE, 4'b1000, 2'd3);
		phy_en = 1'b0;
		remote_en = 1'b0;
		local_en = 1'b0;
		wait_for_words(40);
	endtask

	task automatic strobe_without_block();
		drive_cycle(1'b1, data_block(), 4'b0, 2'd0);
		drive_cycle(1'b0, '0, 4'b0, 2'd0);
		len_next[1] = pktlen_t'(rand_bits(18));
		drive_cycle(1'b0, '0, 4'b0010, 2'd0);
		wait_for_words(20);
	endtask

	task automatic idle_report();
		drive_cycle(1'b1, data_block(), 4'b0, 2'd0);
		idle_seen = 0;
		repeat ((1 << IDLE_COUNT_BITS) + 300)
			drive_cycle(1'b1, P_IDLE, 4'b0, 2'd0);
		wait_for_words(20);
		check("idle reports", {31'b0, idle_seen != 0}, 1);
		drive_cycle(1'b1, data_block(), 4'b0, 2'd0);
		idle_seen = 0;
		repeat (300)
			drive_cycle(1'b1, P_IDLE, 4'b0, 2'd0);
		wait_for_words(20);
		check("idle reports after break", idle_seen, 0);
	endtask

	initial
	begin
		lfsr_state = 32'h2fe4;
		errors = 0;
		start_errors = 0;
		tests_failed = 0;
		tests_run = 0;
		idle_count = 0;
		idle_seen = 0;
		model_count = '0;
		model_last_sync = 2'b11;
		hold_prev = 1'b0;
		remote_en = 1'b0;
		local_en = 1'b0;
		phy_en = 1'b0;
		ready_en = 1'b1;
		i_reset = 1'b1;
		i_phy_fault = 1'b0;
		i_remote_fault = 1'b0;
		i_local_fault = 1'b0;
		i_p66b_valid = 1'b0;
		i_p66b_data = '0;
		strobe = '0;
		i_dbg_ready = 1'b1;
		for (int c = 0; c < 4; c++)
		begin
			pktlen[c] = '0;
			len_next[c] = '0;
		end
		repeat (5)
			@(posedge i_clk);
		i_reset <= 1'b0;
		// Let the fault synchronizer flush
		repeat (4)
			drive_cycle(1'b0, '0, 4'b0, 2'd0);
		single_rx_word();
		report_test("single rx word");
		all_four_strobes();
		report_test("all four strobes");
		random_backpressure();
		report_test("random back-pressure");
		fault_priority();
		report_test("fault priority");
		strobe_without_block();
		report_test("strobe without block");
		idle_report();
		report_test("idle report");
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
logic/netdbg_pkg.sv
logic/line_status.sv
logic/idle_monitor.sv
logic/pkt_stat_channel.sv
logic/dbg_arbiter.sv
logic/netdbggen.sv
tb/netdbggen_props.sv
tb/netdbggen_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module netdbggen_tb -f all.f

sim_out=$(./obj_dir/Vnetdbggen_tb)
echo "$sim_out"

if grep -qx "TB PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1
